// File: noc.f
verilog/noc_pkg.sv
verilog/noc_input_buffer.sv
verilog/noc_output_arbiter.sv
verilog/noc_router.sv
verilog/noc_mesh.sv
tb/noc_scoreboard.sv
tb/noc_assertions.sv
tb/tb_noc_mesh.sv

// File: run_sim.sh
#!/bin/sh
# Builds the mesh testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_noc_mesh -f noc.f -o sim_noc
# Assertion errors must not stop the run, the testbench prints the verdict itself
./obj_dir/sim_noc +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test OK$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: tb/noc_assertions.sv
// ==============================
// Handshake and reset properties of the local mesh ports
// Bound into every noc_mesh
// ==============================
`default_nettype none

module noc_assertions import noc_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input link_req_t  in_req   [noc_nodes],
  input link_resp_t in_resp  [noc_nodes],
  input link_req_t  out_req  [noc_nodes],
  input link_resp_t out_resp [noc_nodes]
);
  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;  // Number of assertion failures so far

  for (genvar n = 0; n < noc_nodes; n++) begin : g_node
    // A waiting injection keeps valid up and its flit unchanged
    a_in_hold : assert property (@(posedge clk) disable iff (!rst_n)
      in_req[n].valid && !in_resp[n].ready |=> in_req[n].valid && $stable(in_req[n].flit))
      else begin
        $error("Injection at node %0d dropped or changed while waiting", n);
        failures++;
      end

    a_out_hold : assert property (@(posedge clk) disable iff (!rst_n)
      out_req[n].valid && !out_resp[n].ready |=> out_req[n].valid && $stable(out_req[n].flit))
      else begin
        $error("Ejection at node %0d dropped or changed while stalled", n);
        failures++;
      end

    // Nothing leaves the mesh in the first cycle after reset
    a_reset_idle : assert property (@(posedge clk) $rose(rst_n) |-> !out_req[n].valid)
      else begin
        $error("Node %0d ejects right after reset", n);
        failures++;
      end

    a_right_node : assert property (@(posedge clk) disable iff (!rst_n)
      out_req[n].valid && out_resp[n].ready |->
        int'(out_req[n].flit.dest_x) * noc_size_y + int'(out_req[n].flit.dest_y) == n)
      else begin
        $error("Node %0d ejects a flit addressed elsewhere", n);
        failures++;
      end
  end

endmodule

bind noc_mesh noc_assertions u_noc_assertions (.*);

`default_nettype wire

// File: tb/noc_scoreboard.sv
// ==============================
// Reference model of the mesh, one ordered queue per (source, destination)
// Samples every port on the rising edge, inputs must be stable there
// ==============================
`default_nettype none

module noc_scoreboard import noc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  link_req_t  in_req   [noc_nodes],
  input  link_resp_t in_resp  [noc_nodes],
  input  link_req_t  out_req  [noc_nodes],
  input  link_resp_t out_resp [noc_nodes],
  input  logic       drain_check,  // Compare the flow counts on this edge
  output int         error_count,
  output int         outstanding   // Accepted but not yet delivered
);
  timeunit 1ns;
  timeprecision 100ps;

  flit_t flow_q   [noc_nodes*noc_nodes][$];  // Expected flits of a flow, oldest first
  int    flow_in  [noc_nodes*noc_nodes];     // Flits accepted per flow
  int    flow_out [noc_nodes*noc_nodes];     // Flits delivered per flow
  int    injected     = 0;
  int    delivered    = 0;
  logic  out_of_reset = 1'b0;                // Low until the first edge after reset

  initial begin
    error_count = 0;
    for (int f = 0; f < noc_nodes*noc_nodes; f++) begin
      flow_in[f]  = 0;
      flow_out[f] = 0;
    end
  end

  assign outstanding = injected - delivered;

  // Node numbering of the mesh: row times the row length plus the column
  function automatic int dest_node(input flit_t f);
    return int'(f.dest_x) * noc_size_y + int'(f.dest_y);
  endfunction

  task automatic check_reset_state();
    for (int n = 0; n < noc_nodes; n++) begin
      if (out_req[n].valid !== 1'b0) begin
        $display("CHECK FAILED t=%0t out_req[%0d].valid expected 0 actual %b",
                 $time, n, out_req[n].valid);
        error_count++;
      end
      if (in_resp[n].ready !== 1'b1) begin
        $display("CHECK FAILED t=%0t in_resp[%0d].ready expected 1 actual %b",
                 $time, n, in_resp[n].ready);
        error_count++;
      end
    end
  endtask

  task automatic record_injection(input int n);
    int f;
    f = n * noc_nodes + dest_node(in_req[n].flit);  // Source is the injecting port
    flow_q[f].push_back(in_req[n].flit);
    flow_in[f]++;
    injected++;
  endtask

  task automatic record_ejection(input int n);
    flit_t act;
    flit_t exp;
    int    f;
    act = out_req[n].flit;
    if (dest_node(act) != n) begin
      $display("CHECK FAILED t=%0t out_req[%0d].flit dest expected node %0d actual node %0d",
               $time, n, n, dest_node(act));
      error_count++;
    end
    f = int'(act.src_id) * noc_nodes + n;
    flow_out[f]++;
    delivered++;
    if (flow_q[f].size() == 0) begin
      // Nothing is owed on this flow, so the flit is a duplicate or was never sent
      $display("ERROR t=%0t node %0d delivered a flit from node %0d that nobody is waiting for",
               $time, n, act.src_id);
      error_count++;
    end else begin
      exp = flow_q[f].pop_front();
      if (act !== exp) begin
        $display("CHECK FAILED t=%0t out_req[%0d].flit expected %h actual %h",
                 $time, n, exp, act);
        error_count++;
      end
    end
  endtask

  task automatic check_drain();
    for (int f = 0; f < noc_nodes*noc_nodes; f++) begin
      if (flow_out[f] != flow_in[f]) begin
        $display("CHECK FAILED t=%0t delivered count node %0d to node %0d expected %0d actual %0d",
                 $time, f / noc_nodes, f % noc_nodes, flow_in[f], flow_out[f]);
        error_count++;
      end
      if (flow_q[f].size() != 0) begin
        $display("ERROR t=%0t flow node %0d to node %0d still owes %0d flits",
                 $time, f / noc_nodes, f % noc_nodes, flow_q[f].size());
        error_count++;
      end
    end
    if (delivered != injected) begin
      $display("CHECK FAILED t=%0t total delivered expected %0d actual %0d",
               $time, injected, delivered);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      out_of_reset = 1'b0;
    end else begin
      if (!out_of_reset) begin
        check_reset_state();  // First edge with reset released
      end
      out_of_reset = 1'b1;
      for (int n = 0; n < noc_nodes; n++) begin
        if (in_req[n].valid && in_resp[n].ready) record_injection(n);
        if (out_req[n].valid && out_resp[n].ready) record_ejection(n);
      end
      if (drain_check) check_drain();  // After this edge's deliveries
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_noc_mesh.sv
// ==============================
// Testbench of the 2x2 mesh with LCG traffic from a fixed seed
// Inputs change on the falling edge, the scoreboard samples on the rising one
// ==============================
`default_nettype none

module tb_noc_mesh import noc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int random_flits   = 200;
  localparam int hot_flits      = 10;  // Per source, all aimed at node 0
  localparam int total_flits    = noc_nodes*noc_nodes + 2*random_flits + noc_nodes*hot_flits;
  localparam int timeout_cycles = total_flits*20 + 200;

  logic       clk = 1'b0;
  logic       rst_n;
  link_req_t  in_req   [noc_nodes];
  link_resp_t in_resp  [noc_nodes];
  link_req_t  out_req  [noc_nodes];
  link_resp_t out_resp [noc_nodes];
  logic       drain_check;
  int         sb_errors;
  int         outstanding;

  logic [31:0] rng_state = 32'h5444_fb7c;
  int          dest_q   [noc_nodes][$];  // Destinations each source still has to send
  logic [5:0]  seq_cnt  [noc_nodes][noc_nodes];
  logic        accepted [noc_nodes];     // Injection went through on the last rising edge
  int          inject_pct;               // Chance in percent that an idle source starts
  logic        backpressure;             // Random ready on the ejection ports
  int          tests_passed  = 0;
  int          tests_failed  = 0;
  int          errs_at_start = 0;
  int          cycle_count   = 0;

  always #50 clk = ~clk;  // 100 ns period

  noc_mesh u_noc_mesh (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_resp  (in_resp),
    .out_req  (out_req),
    .out_resp (out_resp)
  );

  noc_scoreboard u_scoreboard (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req      (in_req),
    .in_resp     (in_resp),
    .out_req     (out_req),
    .out_resp    (out_resp),
    .drain_check (drain_check),
    .error_count (sb_errors),
    .outstanding (outstanding)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Middle bits only, the low bits of an LCG repeat quickly
  function automatic int rnd_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[23:8]) % n;
  endfunction

  function automatic int total_errors();
    return sb_errors + u_noc_mesh.u_noc_assertions.failures;
  endfunction

  function automatic logic sources_idle();
    for (int s = 0; s < noc_nodes; s++) begin
      if (dest_q[s].size() != 0 || in_req[s].valid) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic load_flit(input int s);
    int          d;
    flit_t       f;
    logic [31:0] r;
    d         = dest_q[s].pop_front();
    r         = next_random();
    f.dest_x  = coord_w'(d / noc_size_y);
    f.dest_y  = coord_w'(d % noc_size_y);
    f.src_id  = 2'(s);
    f.seq     = seq_cnt[s][d];  // Numbered per destination
    f.payload = r[31:16];
    seq_cnt[s][d] = seq_cnt[s][d] + 6'd1;
    in_req[s].flit  = f;
    in_req[s].valid = 1'b1;
  endtask

  always @(posedge clk) begin
    for (int s = 0; s < noc_nodes; s++) begin
      accepted[s] <= in_req[s].valid && in_resp[s].ready;
    end
  end

  // Sources hold a flit until it is taken, ejection ready is random under back-pressure
  always @(negedge clk) begin
    if (rst_n) begin
      for (int s = 0; s < noc_nodes; s++) begin
        if (in_req[s].valid && accepted[s]) in_req[s].valid = 1'b0;
        if (!in_req[s].valid && dest_q[s].size() > 0 && rnd_below(100) < inject_pct) begin
          load_flit(s);
        end
      end
      for (int d = 0; d < noc_nodes; d++) begin
        out_resp[d].ready = backpressure ? (rnd_below(2) == 1) : 1'b1;
      end
    end
  end

  task automatic queue_random_flits(input int count);
    int s;
    int d;
    repeat (count) begin
      s = rnd_below(noc_nodes);
      d = rnd_below(noc_nodes);
      dest_q[s].push_back(d);
    end
  endtask

  // Settled view just after the rising edge, the watchdog bounds this loop
  task automatic wait_drained();
    @(posedge clk);
    #1;
    while (!sources_idle() || outstanding != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_drain_now();
    drain_check = 1'b1;
    @(posedge clk);
    #1;
    drain_check = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = total_errors() - errs_at_start;
    if (errs == 0) begin
      tests_passed++;
      $display("%-22s pass", name);
    end else begin
      tests_failed++;
      $display("%-22s fail with %0d errors", name, errs);
    end
    errs_at_start = total_errors();
  endtask

  initial begin
    rst_n        = 1'b0;
    drain_check  = 1'b0;
    inject_pct   = 100;
    backpressure = 1'b0;
    for (int n = 0; n < noc_nodes; n++) begin
      in_req[n]         = '0;
      out_resp[n].ready = 1'b1;
      for (int d = 0; d < noc_nodes; d++) seq_cnt[n][d] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    finish_test("reset_state");  // Checked on the first edge out of reset

    for (int s = 0; s < noc_nodes; s++) begin
      for (int d = 0; d < noc_nodes; d++) begin
        dest_q[s].push_back(d);  // One flit in flight at a time
        wait_drained();
      end
    end
    check_drain_now();
    finish_test("single_flit_routing");

    inject_pct = 75;
    queue_random_flits(random_flits);
    wait_drained();
    check_drain_now();
    finish_test("random_traffic");

    backpressure = 1'b1;
    queue_random_flits(random_flits);
    wait_drained();
    backpressure = 1'b0;
    check_drain_now();
    finish_test("random_backpressure");

    inject_pct = 100;  // Every source at full rate into node 0
    for (int s = 0; s < noc_nodes; s++) begin
      repeat (hot_flits) dest_q[s].push_back(0);
    end
    wait_drained();
    check_drain_now();
    finish_test("hotspot_node0");

    check_drain_now();
    finish_test("drain");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles, %0d flits still in the mesh",
             timeout_cycles, outstanding);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/noc_input_buffer.sv
// ==============================
// Two-entry input FIFO of one router port
// Ready comes from the registered count only
// pop must only be raised while head_valid is high
// ==============================
`default_nettype none

module noc_input_buffer import noc_pkg::*; #(
  parameter int router_x = 0,  // Row of the owning router
  parameter int router_y = 0   // Column of the owning router
) (
  input  logic       clk,
  input  logic       rst_n,
  input  link_req_t  in_req,      // Upstream sender
  output link_resp_t in_resp,
  output flit_t      head_flit,   // Oldest stored flit
  output logic       head_valid,
  output port_e      head_port,   // Output port the head flit needs
  input  logic       pop          // Head leaves this cycle
);

  flit_t      mem [2];   // Flit storage
  logic       wr_ptr;    // Next slot to write
  logic       rd_ptr;    // Slot holding the head
  logic [1:0] count;     // Stored flits, 0 to 2
  logic       push;

  // Ready only looks at the count register, so it never waits on downstream logic
  assign in_resp.ready = (count < 2'd2);

  // A transfer happens when the sender's valid meets our ready
  assign push = in_req.valid && in_resp.ready;

  assign head_valid = (count != 2'd0);
  assign head_flit  = mem[rd_ptr];  // Ignored by the router while empty

  // Routing is resolved once here, the crossbar and the arbiters reuse the result
  assign head_port = route_port(head_flit.dest_x, head_flit.dest_y, router_x, router_y);

  // Pointers and count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;  // Empty, so ready is high out of reset
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;  // Two slots, the pointer simply toggles
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Push and pop in the same cycle leave the count unchanged
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  // Storage write, the flit is visible at the head one cycle after the transfer
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_req.flit;
    end
  end

endmodule

`default_nettype wire

// File: verilog/noc_mesh.sv
// ==============================
// 2x2 mesh top, node index is y + x*noc_size_y
// Edge inputs are idle and edge outputs never see ready
// Only the local ports leave this module
// ==============================
`default_nettype none

module noc_mesh import noc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  link_req_t  in_req   [noc_nodes],  // Injection into each local port
  output link_resp_t in_resp  [noc_nodes],
  output link_req_t  out_req  [noc_nodes],  // Ejection from each local port
  input  link_resp_t out_resp [noc_nodes]
);

  // Vertical boundaries, entry y + x*noc_size_y sits above row x
  link_req_t  up_req  [noc_size_y*(noc_size_x+1)];  // Flits moving north
  link_resp_t up_resp [noc_size_y*(noc_size_x+1)];
  link_req_t  dn_req  [noc_size_y*(noc_size_x+1)];  // Flits moving south
  link_resp_t dn_resp [noc_size_y*(noc_size_x+1)];

  // Horizontal boundaries, entry y + x*(noc_size_y+1) sits left of column y
  link_req_t  lt_req  [(noc_size_y+1)*noc_size_x];  // Flits moving west
  link_resp_t lt_resp [(noc_size_y+1)*noc_size_x];
  link_req_t  rt_req  [(noc_size_y+1)*noc_size_x];  // Flits moving east
  link_resp_t rt_resp [(noc_size_y+1)*noc_size_x];

  for (genvar x = 0; x < noc_size_x; x++) begin : g_row
    for (genvar y = 0; y < noc_size_y; y++) begin : g_col
      localparam int local_idx = y + x*noc_size_y;
      localparam int north_idx = y + x*noc_size_y;        // Boundary above
      localparam int south_idx = y + (x+1)*noc_size_y;    // Boundary below
      localparam int west_idx  = y + x*(noc_size_y+1);    // Boundary on the left
      localparam int east_idx  = (y+1) + x*(noc_size_y+1);

      link_req_t  r_in_req   [n_ports];  // Router side of the links, by port_e
      link_resp_t r_in_resp  [n_ports];
      link_req_t  r_out_req  [n_ports];
      link_resp_t r_out_resp [n_ports];

      noc_router #(
        .router_x (x),
        .router_y (y)
      ) u_router (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (r_in_req),
        .in_resp  (r_in_resp),
        .out_req  (r_out_req),
        .out_resp (r_out_resp)
      );

      // Arriving flits
      assign r_in_req[local_p] = in_req[local_idx];
      assign r_in_req[north_p] = dn_req[north_idx];  // Came down from the row above
      assign r_in_req[south_p] = up_req[south_idx];
      assign r_in_req[west_p]  = rt_req[west_idx];
      assign r_in_req[east_p]  = lt_req[east_idx];

      assign in_resp[local_idx] = r_in_resp[local_p];
      assign dn_resp[north_idx] = r_in_resp[north_p];
      assign up_resp[south_idx] = r_in_resp[south_p];
      assign rt_resp[west_idx]  = r_in_resp[west_p];
      assign lt_resp[east_idx]  = r_in_resp[east_p];

      // Leaving flits
      assign out_req[local_idx] = r_out_req[local_p];
      assign up_req[north_idx]  = r_out_req[north_p];
      assign dn_req[south_idx]  = r_out_req[south_p];
      assign lt_req[west_idx]   = r_out_req[west_p];
      assign rt_req[east_idx]   = r_out_req[east_p];

      assign r_out_resp[local_p] = out_resp[local_idx];
      assign r_out_resp[north_p] = up_resp[north_idx];
      assign r_out_resp[south_p] = dn_resp[south_idx];
      assign r_out_resp[west_p]  = lt_resp[west_idx];
      assign r_out_resp[east_p]  = rt_resp[east_idx];

      // Edges, nobody drives into the mesh and nobody takes flits off it
      if (x == 0) begin : g_north_edge
        assign dn_req[north_idx]  = '0;
        assign up_resp[north_idx] = '0;
      end
      if (x == noc_size_x-1) begin : g_south_edge
        assign up_req[south_idx]  = '0;
        assign dn_resp[south_idx] = '0;
      end
      if (y == 0) begin : g_west_edge
        assign rt_req[west_idx]  = '0;
        assign lt_resp[west_idx] = '0;
      end
      if (y == noc_size_y-1) begin : g_east_edge
        assign lt_req[east_idx]  = '0;
        assign rt_resp[east_idx] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/noc_output_arbiter.sv
// ==============================
// Round-robin arbiter of one output port
// Requests must stay up until they are served
// ==============================
`default_nettype none

module noc_output_arbiter import noc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  port_mask_t req,        // Inputs whose head flit wants this output
  input  logic       out_ready,  // Ready of the link behind this output
  output port_mask_t grant,      // One-hot, or zero without requests
  output logic       out_valid
);

  logic [$bits(port_e)-1:0] ptr_q;  // Input with the highest priority
  logic [$bits(port_e)-1:0] win;    // Input granted this cycle

  // Scan from the far end back to the pointer, the last hit is the nearest one
  always_comb begin
    grant = '0;
    win   = ptr_q;
    for (int i = n_ports-1; i >= 0; i--) begin
      int idx;
      idx = int'(ptr_q) + i;
      if (idx >= n_ports) begin
        idx = idx - n_ports;  // Wrap around the five ports
      end
      if (req[idx]) begin
        grant      = '0;
        grant[idx] = 1'b1;
        win        = ($bits(port_e))'(idx);
      end
    end
  end

  assign out_valid = |req;  // Some head flit always wins when any request exists

  // While the winner stalls the pointer parks on it, so nobody can take over the
  // grant and the flit on the link stays the same
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (out_valid) begin
      if (out_ready) begin
        ptr_q <= (win == ($bits(port_e))'(n_ports-1)) ? '0 : win + 1'b1;  // Past winner
      end else begin
        ptr_q <= win;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/noc_pkg.sv
// ==============================
// Shared types for the 2x2 packet mesh
// Rows are x and columns are y, row 0 at the north edge
// One virtual channel, single-flit packets only
// ==============================
`default_nettype none

package noc_pkg;

  localparam int noc_size_x = 2;                      // Number of rows
  localparam int noc_size_y = 2;                      // Number of columns
  localparam int noc_nodes  = noc_size_x*noc_size_y;  // Routers, one endpoint each
  localparam int coord_w    = 1;                      // Bits per coordinate
  localparam int payload_w  = 16;
  localparam int n_ports    = 5;                      // Local plus four mesh directions

  // A packet is a single flit, so the header rides with the payload
  typedef struct packed {
    logic [coord_w-1:0]   dest_x;   // Destination row
    logic [coord_w-1:0]   dest_y;   // Destination column
    logic [1:0]           src_id;   // Sending node, y + x*noc_size_y
    logic [5:0]           seq;      // Per-flow sequence number
    logic [payload_w-1:0] payload;
  } flit_t;

  // Forward half of a link, driven by the sender
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_req_t;

  // Backward half of a link, driven by the receiver
  typedef struct packed {
    logic ready;
  } link_resp_t;

  typedef enum logic [2:0] {
    local_p,
    north_p,
    south_p,
    east_p,
    west_p
  } port_e;

  // One bit per port, indexed by port_e
  typedef logic [n_ports-1:0] port_mask_t;

  // Dimension-ordered routing, the row is resolved before the column
  function automatic port_e route_port(input logic [coord_w-1:0] dest_x,
                                       input logic [coord_w-1:0] dest_y,
                                       input int router_x,
                                       input int router_y);
    port_e dir;
    if (int'(dest_x) < router_x)      dir = north_p;  // Smaller row lies north
    else if (int'(dest_x) > router_x) dir = south_p;
    else if (int'(dest_y) < router_y) dir = west_p;   // Same row, move along it
    else if (int'(dest_y) > router_y) dir = east_p;
    else                              dir = local_p;  // Arrived
    return dir;
  endfunction

endpackage

`default_nettype wire

// File: verilog/noc_router.sv
// ==============================
// Five-port router, one input buffer and one arbiter per port
// A free hop costs one cycle, there is no output register
// ==============================
`default_nettype none

module noc_router import noc_pkg::*; #(
  parameter int router_x = 0,  // Row in the mesh
  parameter int router_y = 0   // Column in the mesh
) (
  input  logic       clk,
  input  logic       rst_n,
  input  link_req_t  in_req   [n_ports],  // Indexed by port_e
  output link_resp_t in_resp  [n_ports],
  output link_req_t  out_req  [n_ports],
  input  link_resp_t out_resp [n_ports]
);

  flit_t      head_flit  [n_ports];  // Head of each input buffer
  logic       head_valid [n_ports];
  port_e      head_port  [n_ports];  // Output wanted by each head
  logic       pop        [n_ports];  // Input buffer loses its head
  port_mask_t req_mask   [n_ports];  // Per output, the inputs asking for it
  port_mask_t grant      [n_ports];  // Per output, the input that won
  logic       out_valid  [n_ports];

  for (genvar p = 0; p < n_ports; p++) begin : g_port
    noc_input_buffer #(
      .router_x (router_x),
      .router_y (router_y)
    ) u_input_buffer (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_req     (in_req[p]),
      .in_resp    (in_resp[p]),
      .head_flit  (head_flit[p]),
      .head_valid (head_valid[p]),
      .head_port  (head_port[p]),
      .pop        (pop[p])
    );

    noc_output_arbiter u_output_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req_mask[p]),
      .out_ready (out_resp[p].ready),
      .grant     (grant[p]),
      .out_valid (out_valid[p])
    );
  end

  // Each valid head requests exactly one output
  always_comb begin
    for (int o = 0; o < n_ports; o++) begin
      req_mask[o] = '0;
      for (int i = 0; i < n_ports; i++) begin
        req_mask[o][i] = head_valid[i] && (head_port[i] == port_e'(o));
      end
    end
  end

  // Crossbar, the grant is one-hot so an OR of the masked heads is enough
  always_comb begin
    for (int o = 0; o < n_ports; o++) begin
      out_req[o].valid = out_valid[o];
      out_req[o].flit  = '0;
      for (int i = 0; i < n_ports; i++) begin
        if (grant[o][i]) begin
          out_req[o].flit = out_req[o].flit | head_flit[i];
        end
      end
    end
  end

  // An input pops when its granted output completes the transfer
  always_comb begin
    for (int i = 0; i < n_ports; i++) begin
      pop[i] = 1'b0;
    end
    for (int o = 0; o < n_ports; o++) begin
      for (int i = 0; i < n_ports; i++) begin
        if (grant[o][i] && out_resp[o].ready) begin
          pop[i] = 1'b1;  // At most one output can grant a given input
        end
      end
    end
  end

endmodule

`default_nettype wire
